/* logic/fe_arith_pkg.sv */
package fe_arith_pkg;

	// widths of the field datapath.
	localparam int FE_W = 256;   // one field element, top bit spare.
	localparam int WIDE_W = 264; // pre-reduction intermediate.
	localparam int RED_W = 255;  // fold point, 2^255 wraps to 19.
	localparam int FOLD_W = 5;   // width of the fold constant.

	// bits above the fold point in a wide value.
	localparam int HI_W = WIDE_W - RED_W;

	typedef logic [FE_W-1:0] fe_t;     // canonical when below p.
	typedef logic [WIDE_W-1:0] wide_t; // unreduced intermediate.

	// the prime 2^255 - 19.
	localparam fe_t FE_P = (fe_t'(1) << RED_W) - fe_t'(19);

	// twice p, 257 bits, bias that keeps a subtraction positive.
	localparam logic [FE_W:0] FE_2P = {FE_P, 1'b0};

	// 2^255 mod p, the multiplier for folded carries.
	localparam logic [FOLD_W-1:0] FOLD_MUL = 5'd19;

endpackage

/* logic/fe_cmd_pkg.sv */
package fe_cmd_pkg;

	import fe_arith_pkg::*;

	// width of the operation code.
	localparam int OP_W = 2;

	// operation select, code 3 is unused.
	typedef enum logic [OP_W-1:0] {
		op_add = 2'd0, // a + b mod p.
		op_sub = 2'd1, // a - b mod p.
		op_mul = 2'd2  // a * b mod p.
	} fe_op_t;

	// request on the command port, tag travels beside it.
	// both operands must already be canonical.
	typedef struct packed {
		fe_op_t op; // what to do.
		fe_t a;     // first operand.
		fe_t b;     // second operand.
	} fe_req_t;     // 514 bits in all.

endpackage

/* logic/fe_prereduce.sv */
`timescale 1ns/1ps

module fe_prereduce
	import fe_arith_pkg::*;
	import fe_cmd_pkg::*;
#(
	parameter int TAG_W = 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             en,      // one request this cycle.
	input  fe_req_t          req,
	input  logic [TAG_W-1:0] tag,
	output logic             out_valid,
	output wide_t            out,     // below 2^260, not yet reduced.
	output logic [TAG_W-1:0] out_tag
);

	// full product of two 255-bit operands.
	logic [2*RED_W-1:0] prod;

	// carry half of the product times 19.
	logic [RED_W+FOLD_W-1:0] fold_hi;

	// candidate results, one per operation.
	wide_t sum_w;
	wide_t dif_w;
	wide_t mul_w;

	wide_t nxt; // selected by opcode.

	always_comb begin
		// canonical operands fit in 255 bits, bit 255 is always clear.
		prod = req.a[RED_W-1:0] * req.b[RED_W-1:0];

		// bits 509:255 weigh 2^255, which is 19 mod p.
		fold_hi = prod[2*RED_W-1:RED_W] * FOLD_MUL;

		// below 2p, no fold needed.
		sum_w = wide_t'(req.a) + wide_t'(req.b);

		// bias by 2p so the difference stays positive.
		// result lands between p and 3p.
		dif_w = wide_t'(req.a) + wide_t'(FE_2P) - wide_t'(req.b);

		// low half plus folded high half, under 20 * 2^255.
		mul_w = wide_t'(prod[RED_W-1:0]) + wide_t'(fold_hi);
	end

	// opcode select.
	always_comb begin
		case (req.op)
			op_add: begin
				nxt = sum_w;
			end
			op_sub: begin
				nxt = dif_w;
			end
			op_mul: begin
				nxt = mul_w;
			end
			default: begin
				nxt = '0; // reserved code gives zero.
			end
		endcase
	end

	// strobe follows en by one cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= en;
		end
	end

	// payload only moves on a live request.
	always_ff @(posedge clk) begin
		if (en) begin
			out     <= nxt;
			out_tag <= tag; // tag rides along untouched.
		end
	end

endmodule

/* logic/x25519_squeeze.sv */
`timescale 1ns/1ps

module x25519_squeeze
	import fe_arith_pkg::*;
#(
	parameter int TAG_W = 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             en,
	input  wide_t            a,       // any 264-bit value.
	input  logic [TAG_W-1:0] tag,
	output logic             out_valid,
	output wide_t            out,     // same value mod p, below 2p.
	output logic [TAG_W-1:0] out_tag
);

	// first stage registers.
	logic                    en_ff;
	logic [RED_W-1:0]        lo_ff;    // bits 254:0.
	logic [HI_W+FOLD_W-1:0]  carry_ff; // 19 * bits 263:255, 14 bits.
	logic [TAG_W-1:0]        tag_ff;

	// valid pipe, two deep.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_ff     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			en_ff     <= en;
			out_valid <= en_ff;
		end
	end

	// split the word and scale the carries.
	always_ff @(posedge clk) begin
		if (en) begin
			lo_ff    <= a[RED_W-1:0];
			carry_ff <= a[WIDE_W-1:RED_W] * FOLD_MUL;
			tag_ff   <= tag;
		end
	end

	// add the carries back in.
	// at most 2^255 + 9709, well under 2p.
	always_ff @(posedge clk) begin
		if (en_ff) begin
			out     <= wide_t'(lo_ff) + wide_t'(carry_ff);
			out_tag <= tag_ff;
		end
	end

endmodule

/* logic/fe_freeze.sv */
`timescale 1ns/1ps

module fe_freeze
	import fe_arith_pkg::*;
#(
	parameter int TAG_W = 1
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             en,
	input  wide_t            a,       // must be below 2p.
	input  logic [TAG_W-1:0] tag,
	output logic             out_valid,
	output fe_t              out,     // canonical, below p.
	output logic [TAG_W-1:0] out_tag
);

	// a - p with one extra bit, top bit is the borrow.
	logic [WIDE_W:0] diff;

	logic ge_p; // input at or above p.

	// one subtractor serves as the compare too.
	always_comb begin
		diff = {1'b0, a} - {1'b0, wide_t'(FE_P)};
		ge_p = ~diff[WIDE_W]; // no borrow, so a >= p.
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= en;
		end
	end

	// since a < 2p, one subtraction is enough.
	// upper bits of a are zero here, both picks fit in fe_t.
	always_ff @(posedge clk) begin
		if (en) begin
			if (ge_p) begin
				out <= diff[FE_W-1:0];
			end else begin
				out <= a[FE_W-1:0];
			end
			out_tag <= tag;
		end
	end

endmodule

/* logic/fe_alu.sv */
`timescale 1ns/1ps

module fe_alu
	import fe_arith_pkg::*;
	import fe_cmd_pkg::*;
#(
	parameter int TAG_W = 8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             en,       // one op per cycle, no stall.
	input  fe_req_t          req,
	input  logic [TAG_W-1:0] tag,      // caller's id for the op.
	output logic             out_valid, // four cycles after en.
	output fe_t              out,
	output logic [TAG_W-1:0] out_tag
);

	// prereduce to squeeze.
	logic             pre_valid;
	wide_t            pre_out;
	logic [TAG_W-1:0] pre_tag;

	// squeeze to freeze.
	logic             sq_valid;
	wide_t            sq_out;
	logic [TAG_W-1:0] sq_tag;

	// cycle 1, raw op and first fold.
	fe_prereduce #(
		.TAG_W (TAG_W)
	) prereduce_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.req       (req),
		.tag       (tag),
		.out_valid (pre_valid),
		.out       (pre_out),
		.out_tag   (pre_tag)
	);

	// cycles 2 and 3, carry fold to below 2p.
	x25519_squeeze #(
		.TAG_W (TAG_W)
	) squeeze_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (pre_valid),
		.a         (pre_out),
		.tag       (pre_tag),
		.out_valid (sq_valid),
		.out       (sq_out),
		.out_tag   (sq_tag)
	);

	// cycle 4, canonical result.
	fe_freeze #(
		.TAG_W (TAG_W)
	) freeze_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (sq_valid),
		.a         (sq_out),
		.tag       (sq_tag),
		.out_valid (out_valid),
		.out       (out),
		.out_tag   (out_tag)
	);

endmodule

/* tb/fe_alu_tb.sv */
`timescale 1ns/1ps

module fe_alu_tb
	import fe_arith_pkg::*;
	import fe_cmd_pkg::*;
();

	localparam int TAG_W = 8;
	localparam int CLK_NS = 4;       // clock period.
	localparam int RESET_CYCLES = 5;
	localparam int LATENCY = 4;      // en to out_valid.
	localparam int MAX_WAIT = 10;    // cycles before a result counts as lost.
	localparam int N_RAND = 6;       // random pairs per op type.
	localparam int OP_CYCLES = 7;    // issue, latency and slack for one op.
	localparam int STREAM_N = 40;

	// reset, then add, sub, mul and the stream, in cycles.
	localparam int TEST_CYCLES = RESET_CYCLES + 8
		+ (4 + (4 + N_RAND) + (5 + N_RAND)) * OP_CYCLES
		+ STREAM_N + 12;
	localparam int MARGIN = 200;

	logic             clk;
	logic             rst_n;
	logic             en;
	fe_req_t          req;
	logic [TAG_W-1:0] tag;
	logic             out_valid;
	fe_t              out;
	logic [TAG_W-1:0] out_tag;

	int               cyc;     // rising edges seen so far.
	logic [TAG_W-1:0] tag_cnt; // next tag for single ops.

	fe_alu #(
		.TAG_W (TAG_W)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.req       (req),
		.tag       (tag),
		.out_valid (out_valid),
		.out       (out),
		.out_tag   (out_tag)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_NS / 2) clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// watchdog, sized from the test lengths.
	initial begin
		#(CLK_NS * (TEST_CYCLES + MARGIN));
		fail_run("watchdog expired before all tests finished");
	end

	// prints the reason, then stops the run.
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_val(input string name, input logic [FE_W-1:0] exp,
		input logic [FE_W-1:0] act);
		if (exp !== act) begin
			fail_run($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
		end
	endtask

	// (a op b) mod p from plain wide arithmetic.
	function automatic fe_t model_op(input fe_op_t op, input fe_t a, input fe_t b);
		logic [511:0] wa;
		logic [511:0] wb;
		logic [511:0] wp;
		logic [511:0] r;
		wa = a;
		wb = b;
		wp = FE_P;
		case (op)
			op_add: r = (wa + wb) % wp;
			op_sub: r = (wa + wp - wb) % wp; // shift up by p, no underflow.
			op_mul: r = (wa * wb) % wp;
			default: r = '0;
		endcase
		return r[FE_W-1:0];
	endfunction

	// random canonical operand.
	function automatic fe_t rand_fe();
		fe_t v;
		int i;
		for (i = 0; i < FE_W / 32; i++) begin
			v[i*32 +: 32] = $urandom;
		end
		v[FE_W-1] = 1'b0; // below 2^255.
		if (v >= FE_P) begin
			v = v - FE_P; // only 19 values land here.
		end
		return v;
	endfunction

	task automatic drive_req(input fe_op_t op, input fe_t a, input fe_t b,
		input logic [TAG_W-1:0] t);
		en = 1'b1;
		req.op = op;
		req.a = a;
		req.b = b;
		tag = t;
	endtask

	// waits on out_valid at falling edges, returns the cycle it was seen.
	task automatic wait_result(input string name, output int seen);
		int waited;
		waited = 0;
		@(negedge clk);
		while (out_valid !== 1'b1) begin
			waited++;
			if (waited > MAX_WAIT) begin
				fail_run($sformatf("%s gave no valid result within %0d cycles",
					name, MAX_WAIT));
			end
			@(negedge clk);
		end
		seen = cyc;
	endtask

	// one isolated op, checked for value, tag and latency.
	task automatic run_op(input string name, input fe_op_t op, input fe_t a,
		input fe_t b, input fe_t exp);
		int issued;
		int seen;
		logic [TAG_W-1:0] t;
		t = tag_cnt;
		tag_cnt = tag_cnt + 1'b1;
		@(posedge clk);
		#1;
		drive_req(op, a, b, t);
		issued = cyc;
		@(posedge clk);
		#1;
		en = 1'b0; // single strobe.
		wait_result(name, seen);
		check_val(name, exp, out);
		check_val({name, " tag"}, t, out_tag);
		check_val({name, " latency"}, LATENCY, seen - issued);
	endtask

	// valid stays low in reset and while idle after it.
	task automatic reset_test();
		int i;
		rst_n = 1'b0;
		for (i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk);
			check_val("reset valid", 0, out_valid);
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			check_val("idle valid", 0, out_valid);
		end
	endtask

	task automatic add_test();
		run_op("add 0+0", op_add, '0, '0, '0);
		run_op("add (p-1)+1", op_add, FE_P - 1, fe_t'(1), '0);
		run_op("add (p-1)+(p-1)", op_add, FE_P - 1, FE_P - 1, FE_P - 2);
		run_op("add 3+4", op_add, fe_t'(3), fe_t'(4), fe_t'(7));
	endtask

	task automatic sub_test();
		fe_t x;
		fe_t y;
		int i;
		x = rand_fe();
		run_op("sub 5-7", op_sub, fe_t'(5), fe_t'(7), FE_P - 2);
		run_op("sub a-a", op_sub, x, x, '0);
		run_op("sub 0-(p-1)", op_sub, '0, FE_P - 1, fe_t'(1));
		run_op("sub (p-1)-0", op_sub, FE_P - 1, '0, FE_P - 1);
		for (i = 0; i < N_RAND; i++) begin
			x = rand_fe();
			y = rand_fe();
			run_op("sub random", op_sub, x, y, model_op(op_sub, x, y));
		end
	endtask

	task automatic mul_test();
		fe_t x;
		fe_t y;
		int i;
		x = rand_fe();
		run_op("mul (p-1)^2", op_mul, FE_P - 1, FE_P - 1, fe_t'(1)); // (-1)^2.
		run_op("mul 2^128*2^128", op_mul, fe_t'(1) << 128, fe_t'(1) << 128,
			fe_t'(38)); // 2^256 is 2*19 mod p.
		run_op("mul x*0", op_mul, x, '0, '0);
		run_op("mul x*1", op_mul, x, fe_t'(1), x);
		run_op("mul 2^254*2", op_mul, fe_t'(1) << 254, fe_t'(2), fe_t'(19));
		for (i = 0; i < N_RAND; i++) begin
			x = rand_fe();
			y = rand_fe();
			run_op("mul random", op_mul, x, y, model_op(op_mul, x, y));
		end
	endtask

	// back to back mixed ops, en high the whole burst.
	task automatic stream_test();
		fe_op_t ops [STREAM_N];
		fe_t xa [STREAM_N];
		fe_t xb [STREAM_N];
		int issued [STREAM_N];
		int di;
		int ci;
		int seen;
		for (di = 0; di < STREAM_N; di++) begin
			ops[di] = fe_op_t'($urandom % 3);
			xa[di] = rand_fe();
			xb[di] = rand_fe();
		end
		fork
			begin
				for (di = 0; di < STREAM_N; di++) begin
					@(posedge clk);
					#1;
					drive_req(ops[di], xa[di], xb[di], TAG_W'(8'h80 + di));
					issued[di] = cyc;
				end
				@(posedge clk);
				#1;
				en = 1'b0;
			end
			begin
				// results must leave in entry order.
				for (ci = 0; ci < STREAM_N; ci++) begin
					wait_result("stream", seen);
					check_val($sformatf("stream op %0d", ci),
						model_op(ops[ci], xa[ci], xb[ci]), out);
					check_val($sformatf("stream op %0d tag", ci),
						TAG_W'(8'h80 + ci), out_tag);
					check_val($sformatf("stream op %0d latency", ci),
						LATENCY, seen - issued[ci]);
				end
			end
		join
	endtask

	initial begin
		void'($urandom(32'hc6bb153e)); // one seed for the run.
		cyc = 0;
		tag_cnt = '0;
		rst_n = 1'b0;
		en = 1'b0;
		req = '0;
		tag = '0;
		reset_test();
		add_test();
		sub_test();
		mul_test();
		stream_test();
		$display("test passed");
		$finish;
	end

endmodule

/* sources.f */
logic/fe_arith_pkg.sv
logic/fe_cmd_pkg.sv
logic/fe_prereduce.sv
logic/x25519_squeeze.sv
logic/fe_freeze.sv
logic/fe_alu.sv
tb/fe_alu_tb.sv
